//--- design/isaPkg.sv
package isaPkg;

  // word and field sizes
  localparam int DATA_W   = 16;  // data path and program counter
  localparam int OP_W     = 4;   // opcode field
  localparam int COND_W   = 3;   // branch condition field
  localparam int OFFSET_W = 9;   // signed word offset of B
  localparam int FLAG_W   = 3;   // {N, V, Z}

  // field positions inside an instruction word
  localparam int OP_LSB     = 12;  // bits 15..12
  localparam int COND_LSB   = 9;   // bits 11..9
  localparam int OFFSET_LSB = 0;   // bits 8..0

  // bit index of each flag in the flags vector
  localparam int FLAG_N = 2;
  localparam int FLAG_V = 1;
  localparam int FLAG_Z = 0;

  // control flow opcodes, everything below 12 is plain sequential code
  localparam logic [OP_W-1:0] OP_B   = 4'd12;  // pc-relative conditional branch
  localparam logic [OP_W-1:0] OP_BR  = 4'd13;  // register conditional branch
  localparam logic [OP_W-1:0] OP_PCS = 4'd14;  // pc save, reports condition only
  localparam logic [OP_W-1:0] OP_HLT = 4'd15;  // stop fetching

  // condition codes
  localparam logic [COND_W-1:0] COND_NE     = 3'd0;  // Z clear
  localparam logic [COND_W-1:0] COND_EQ     = 3'd1;  // Z set
  localparam logic [COND_W-1:0] COND_GT     = 3'd2;  // Z and N clear
  localparam logic [COND_W-1:0] COND_LT     = 3'd3;  // N set
  localparam logic [COND_W-1:0] COND_GE     = 3'd4;  // Z set or N clear
  localparam logic [COND_W-1:0] COND_LE     = 3'd5;  // N or Z set
  localparam logic [COND_W-1:0] COND_OVFL   = 3'd6;  // V set
  localparam logic [COND_W-1:0] COND_ALWAYS = 3'd7;  // unconditional

endpackage

//--- design/fetchPkg.sv
package fetchPkg;

  // credit flow toward decode
  localparam int                  CREDIT_W      = 3;     // counter holds 0..7
  localparam logic [CREDIT_W-1:0] FETCH_CREDITS = 3'd4;  // slots in the decode buffer

  // instruction memory geometry
  localparam int IMEM_DEPTH = 256;                 // words
  localparam int IMEM_AW    = $clog2(IMEM_DEPTH);  // 8 bit word address

  // host configuration map
  localparam int                CFG_AW     = 2;
  localparam logic [CFG_AW-1:0] CFG_FLAGS  = 2'd0;  // {N, V, Z} in bits 2..0
  localparam logic [CFG_AW-1:0] CFG_TARGET = 2'd1;  // BR destination
  localparam logic [CFG_AW-1:0] CFG_RUN    = 2'd2;  // run enable in bit 0
  localparam logic [CFG_AW-1:0] CFG_STATUS = 2'd3;  // read only

  localparam int RUN_BIT         = 0;  // run enable position
  localparam int STATUS_HALT_BIT = 0;  // halted position in status word

endpackage

//--- design/pcControl.sv
`timescale 1ns/1ps

// next pc resolution for one instruction, purely combinational
module pcControl (
  input  logic [isaPkg::DATA_W-1:0] pc,            // address of the instruction in hand
  input  logic [isaPkg::DATA_W-1:0] instr,         // raw instruction word
  input  logic [isaPkg::FLAG_W-1:0] flags,         // {N, V, Z}
  input  logic [isaPkg::DATA_W-1:0] branchTarget,  // register value used by BR
  output logic [isaPkg::DATA_W-1:0] nextPc,        // where fetch goes next
  output logic                      branchTaken    // condition met on B, BR or PCS
);
  import isaPkg::*;

  logic [OP_W-1:0]     opcode;
  logic [COND_W-1:0]   cond;
  logic [OFFSET_W-1:0] offset;
  logic                flagN;
  logic                flagV;
  logic                flagZ;
  logic [DATA_W-1:0]   pcPlus2;      // sequential successor
  logic [DATA_W-1:0]   offsetBytes;  // sign extended, scaled to bytes
  logic [DATA_W-1:0]   pcImm;        // B destination
  logic                condMet;
  logic                isBranchOp;

  // field split
  assign opcode = instr[OP_LSB +: OP_W];
  assign cond   = instr[COND_LSB +: COND_W];
  assign offset = instr[OFFSET_LSB +: OFFSET_W];

  assign flagN = flags[FLAG_N];
  assign flagV = flags[FLAG_V];
  assign flagZ = flags[FLAG_Z];

  // address arithmetic
  assign pcPlus2     = pc + DATA_W'(2);
  assign offsetBytes = {{(DATA_W-OFFSET_W-1){offset[OFFSET_W-1]}}, offset, 1'b0};  // word to byte
  assign pcImm       = pcPlus2 + offsetBytes;  // relative to the fall-through address

  // condition table against the current flags
  always_comb begin
    unique case (cond)
      COND_NE:     condMet = ~flagZ;
      COND_EQ:     condMet = flagZ;
      COND_GT:     condMet = ~flagZ & ~flagN;
      COND_LT:     condMet = flagN;
      COND_GE:     condMet = flagZ | ~flagN;
      COND_LE:     condMet = flagN | flagZ;
      COND_OVFL:   condMet = flagV;
      COND_ALWAYS: condMet = 1'b1;
    endcase
  end

  // destination select by opcode
  always_comb begin
    case (opcode)
      OP_B:    nextPc = condMet ? pcImm : pcPlus2;
      OP_BR:   nextPc = condMet ? branchTarget : pcPlus2;
      OP_HLT:  nextPc = pc;       // park on the halt itself
      default: nextPc = pcPlus2;  // PCS and all sequential opcodes
    endcase
  end

  // PCS reports the condition although it never redirects
  assign isBranchOp  = (opcode == OP_B) | (opcode == OP_BR) | (opcode == OP_PCS);
  assign branchTaken = isBranchOp & condMet;

endmodule

//--- design/fetchCtrlRegs.sv
`timescale 1ns/1ps

// host programmable registers that steer the fetch unit
module fetchCtrlRegs (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        cfgWe,         // host write strobe
  input  logic [fetchPkg::CFG_AW-1:0] cfgAddr,
  input  logic [isaPkg::DATA_W-1:0]   cfgWdata,
  output logic [isaPkg::DATA_W-1:0]   cfgRdata,      // combinational readback
  input  logic                        halted,        // from fetch unit
  output logic [isaPkg::FLAG_W-1:0]   flags,         // {N, V, Z} for condition checks
  output logic [isaPkg::DATA_W-1:0]   branchTarget,  // BR destination
  output logic                        run,           // fetch enable
  output logic                        clearHalt      // one cycle pulse on run=1 write
);
  import isaPkg::*;
  import fetchPkg::*;

  logic flagsWe;
  logic targetWe;
  logic runWe;

  // address decode, the status address has no write path
  assign flagsWe  = cfgWe & (cfgAddr == CFG_FLAGS);
  assign targetWe = cfgWe & (cfgAddr == CFG_TARGET);
  assign runWe    = cfgWe & (cfgAddr == CFG_RUN);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags        <= '0;
      branchTarget <= '0;
      run          <= 1'b0;
    end else begin
      if (flagsWe)  flags        <= cfgWdata[FLAG_W-1:0];
      if (targetWe) branchTarget <= cfgWdata;
      if (runWe)    run          <= cfgWdata[RUN_BIT];
    end
  end

  // restart strobe, lands on the same edge as the run update
  assign clearHalt = runWe & cfgWdata[RUN_BIT];

  // readback mux
  always_comb begin
    cfgRdata = '0;
    case (cfgAddr)
      CFG_FLAGS:  cfgRdata[FLAG_W-1:0]      = flags;
      CFG_TARGET: cfgRdata                  = branchTarget;
      CFG_RUN:    cfgRdata[RUN_BIT]         = run;
      CFG_STATUS: cfgRdata[STATUS_HALT_BIT] = halted;
      default:    cfgRdata                  = '0;
    endcase
  end

  // a restart leaves fetch enabled on the next cycle
  restartEnablesRunAst: assert property (
    @(posedge clk) disable iff (!rstN)
    clearHalt |=> run
  ) else $error("run not set after a restart write");

endmodule

//--- design/instrMem.sv
`timescale 1ns/1ps

// word wide program store, host writes and fetch reads
module instrMem (
  input  logic                         clk,
  input  logic                         memWe,     // host load strobe
  input  logic [fetchPkg::IMEM_AW-1:0] memAddr,   // host word address
  input  logic [isaPkg::DATA_W-1:0]    memWdata,
  input  logic [fetchPkg::IMEM_AW-1:0] imemAddr,  // fetch word address
  output logic [isaPkg::DATA_W-1:0]    imemData   // same cycle read data
);
  import isaPkg::*;
  import fetchPkg::*;

  logic [DATA_W-1:0] mem [IMEM_DEPTH];  // loaded by the host before run

  // write port, visible to the reader after the edge
  always_ff @(posedge clk) begin
    if (memWe) begin
      mem[memAddr] <= memWdata;
    end
  end

  // asynchronous read port
  assign imemData = mem[imemAddr];

endmodule

//--- design/fetchUnit.sv
`timescale 1ns/1ps

// program counter, credit accounting and instruction issue toward decode
module fetchUnit (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         run,           // fetch enable from host
  input  logic                         clearHalt,     // restart pulse
  output logic                         halted,        // set when HLT issues
  input  logic [isaPkg::FLAG_W-1:0]    flags,         // {N, V, Z}
  input  logic [isaPkg::DATA_W-1:0]    branchTarget,  // BR destination
  output logic [fetchPkg::IMEM_AW-1:0] imemAddr,      // word address into memory
  input  logic [isaPkg::DATA_W-1:0]    imemData,      // instruction at pc
  input  logic                         creditReturn,  // decode freed one slot
  output logic                         outValid,      // one cycle per issued instruction
  output logic [isaPkg::DATA_W-1:0]    outInstr,
  output logic [isaPkg::DATA_W-1:0]    outPc,
  output logic                         outBranch      // branchTaken of outInstr
);
  import isaPkg::*;
  import fetchPkg::*;

  logic [DATA_W-1:0]   pc;
  logic [DATA_W-1:0]   nextPc;       // resolved successor of pc
  logic                branchTaken;
  logic [CREDIT_W-1:0] creditCnt;    // free slots downstream
  logic                haveCredit;
  logic                issue;        // instruction leaves this cycle
  logic                isHlt;

  // byte pc to word index, bit 0 is always zero
  assign imemAddr = pc[IMEM_AW:1];

  assign haveCredit = (creditCnt != '0);
  assign issue      = run & ~halted & haveCredit;
  assign isHlt      = (imemData[OP_LSB +: OP_W] == OP_HLT);

  pcControl u_pcControl (
    .pc           (pc),
    .instr        (imemData),
    .flags        (flags),
    .branchTarget (branchTarget),
    .nextPc       (nextPc),
    .branchTaken  (branchTaken)
  );

  // program counter, holds while stalled or halted
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else if (issue) begin
      pc <= nextPc;
    end
  end

  // credit counter, spend and return may coincide
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      creditCnt <= FETCH_CREDITS;
    end else begin
      case ({issue, creditReturn})
        2'b10:   creditCnt <= creditCnt - 1'b1;  // spend only
        2'b01:   creditCnt <= creditCnt + 1'b1;  // return only
        default: creditCnt <= creditCnt;         // idle or both
      endcase
    end
  end

  // halt state
  // a HLT issuing in the restart cycle wins over the clear
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      halted <= 1'b0;
    end else if (issue && isHlt) begin
      halted <= 1'b1;
    end else if (clearHalt) begin
      halted <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= issue;  // single cycle strobe per instruction
    end
  end

  // issued instruction and its context
  always_ff @(posedge clk) begin
    if (issue) begin
      outInstr  <= imemData;
      outPc     <= pc;
      outBranch <= branchTaken;
    end
  end

  // decode never returns more than it was given
  creditBoundAst: assert property (
    @(posedge clk) disable iff (!rstN)
    creditCnt <= FETCH_CREDITS
  ) else $error("credit count above FETCH_CREDITS");

  // each issue takes one credit unless a return lands on the same edge
  issueSpendsCreditAst: assert property (
    @(posedge clk) disable iff (!rstN)
    outValid && !$past(creditReturn) |-> creditCnt == $past(creditCnt) - 1'b1
  ) else $error("issue did not spend a credit");

endmodule

//--- design/fetchTop.sv
`timescale 1ns/1ps

// fetch front end: program store, host registers and fetch unit
module fetchTop (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         memWe,         // program load
  input  logic [fetchPkg::IMEM_AW-1:0] memAddr,
  input  logic [isaPkg::DATA_W-1:0]    memWdata,
  input  logic                         cfgWe,         // register access
  input  logic [fetchPkg::CFG_AW-1:0]  cfgAddr,
  input  logic [isaPkg::DATA_W-1:0]    cfgWdata,
  output logic [isaPkg::DATA_W-1:0]    cfgRdata,
  input  logic                         creditReturn,  // from decode
  output logic                         outValid,      // toward decode
  output logic [isaPkg::DATA_W-1:0]    outInstr,
  output logic [isaPkg::DATA_W-1:0]    outPc,
  output logic                         outBranch
);
  import isaPkg::*;
  import fetchPkg::*;

  logic [FLAG_W-1:0]  flags;
  logic [DATA_W-1:0]  branchTarget;
  logic               run;
  logic               clearHalt;
  logic               halted;
  logic [IMEM_AW-1:0] imemAddr;
  logic [DATA_W-1:0]  imemData;

  instrMem u_instrMem (
    .clk      (clk),
    .memWe    (memWe),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .imemAddr (imemAddr),
    .imemData (imemData)
  );

  fetchCtrlRegs u_fetchCtrlRegs (
    .clk          (clk),
    .rstN         (rstN),
    .cfgWe        (cfgWe),
    .cfgAddr      (cfgAddr),
    .cfgWdata     (cfgWdata),
    .cfgRdata     (cfgRdata),
    .halted       (halted),
    .flags        (flags),
    .branchTarget (branchTarget),
    .run          (run),
    .clearHalt    (clearHalt)
  );

  fetchUnit u_fetchUnit (
    .clk          (clk),
    .rstN         (rstN),
    .run          (run),
    .clearHalt    (clearHalt),
    .halted       (halted),
    .flags        (flags),
    .branchTarget (branchTarget),
    .imemAddr     (imemAddr),
    .imemData     (imemData),
    .creditReturn (creditReturn),
    .outValid     (outValid),
    .outInstr     (outInstr),
    .outPc        (outPc),
    .outBranch    (outBranch)
  );

endmodule

//--- dv/fetchTb.sv
`timescale 1ns/1ps

module fetchTb;
  import isaPkg::*;
  import fetchPkg::*;

  localparam int CLK_PERIOD = 100;  // ns
  localparam int NUM_ROWS   = 22;   // entries added in buildTable
  localparam int ISSUE_WAIT = 20;   // cycles allowed for one issue
  localparam logic [DATA_W-1:0] HLT_INSTR = {OP_HLT, {(DATA_W-OP_W){1'b0}}};

  logic                clk;
  logic                rstN;
  logic                memWe;
  logic [IMEM_AW-1:0]  memAddr;
  logic [DATA_W-1:0]   memWdata;
  logic                cfgWe;
  logic [CFG_AW-1:0]   cfgAddr;
  logic [DATA_W-1:0]   cfgWdata;
  logic [DATA_W-1:0]   cfgRdata;
  logic                creditReturn;
  logic                outValid;
  logic [DATA_W-1:0]   outInstr;
  logic [DATA_W-1:0]   outPc;
  logic                outBranch;

  // stimulus table, one entry per column
  logic [FLAG_W-1:0]   rowFlags [$];  // {N, V, Z}
  logic [OP_W-1:0]     rowOp [$];
  logic [COND_W-1:0]   rowCond [$];
  logic                rowTaken [$];  // expected condition result

  integer              seed;
  integer              rnd;
  int                  checksRun;
  int                  i;
  logic [DATA_W-1:0]   curPc;      // pc parked in the DUT with no credit
  logic [DATA_W-1:0]   hltPc;
  logic [DATA_W-1:0]   tgt;
  logic [DATA_W-1:0]   instr;
  logic [DATA_W-1:0]   expNext;
  logic [DATA_W-1:0]   rdata;
  logic [OFFSET_W-1:0] off;

  fetchTop u_fetchTop (
    .clk          (clk),
    .rstN         (rstN),
    .memWe        (memWe),
    .memAddr      (memAddr),
    .memWdata     (memWdata),
    .cfgWe        (cfgWe),
    .cfgAddr      (cfgAddr),
    .cfgWdata     (cfgWdata),
    .cfgRdata     (cfgRdata),
    .creditReturn (creditReturn),
    .outValid     (outValid),
    .outInstr     (outInstr),
    .outPc        (outPc),
    .outBranch    (outBranch)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic endWithFailure();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checksRun++;
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      endWithFailure();
    end
  endtask

  task automatic addRow(input logic [FLAG_W-1:0] f, input logic [OP_W-1:0] op,
                        input logic [COND_W-1:0] c, input logic taken);
    rowFlags.push_back(f);
    rowOp.push_back(op);
    rowCond.push_back(c);
    rowTaken.push_back(taken);
  endtask

  // taken column worked out by hand from the condition rules
  task automatic buildTable();
    addRow(3'b000, OP_B, COND_NE, 1'b1);
    addRow(3'b001, OP_B, COND_NE, 1'b0);
    addRow(3'b001, OP_B, COND_EQ, 1'b1);
    addRow(3'b100, OP_B, COND_EQ, 1'b0);
    addRow(3'b000, OP_B, COND_GT, 1'b1);
    addRow(3'b100, OP_B, COND_GT, 1'b0);
    addRow(3'b100, OP_B, COND_LT, 1'b1);
    addRow(3'b010, OP_B, COND_LT, 1'b0);
    addRow(3'b001, OP_B, COND_GE, 1'b1);
    addRow(3'b100, OP_B, COND_GE, 1'b0);
    addRow(3'b101, OP_B, COND_LE, 1'b1);
    addRow(3'b010, OP_B, COND_LE, 1'b0);
    addRow(3'b010, OP_B, COND_OVFL, 1'b1);
    addRow(3'b101, OP_B, COND_OVFL, 1'b0);
    addRow(3'b000, OP_B, COND_ALWAYS, 1'b1);
    addRow(3'b001, OP_BR, COND_EQ, 1'b1);
    addRow(3'b000, OP_BR, COND_LT, 1'b0);
    addRow(3'b110, OP_BR, COND_ALWAYS, 1'b1);
    addRow(3'b000, OP_PCS, COND_GE, 1'b1);
    addRow(3'b000, OP_PCS, COND_OVFL, 1'b0);
    addRow(3'b111, 4'd3, COND_ALWAYS, 1'b0);  // plain opcode, condition ignored
    addRow(3'b000, 4'd0, COND_NE, 1'b0);
  endtask

  // non-branch word tagged with its own word address
  function automatic logic [DATA_W-1:0] fillerAt(input logic [DATA_W-1:0] pc);
    return {4'h1, 4'h0, pc[IMEM_AW:1]};
  endfunction

  function automatic logic [DATA_W-1:0] expectedNext(input logic [OP_W-1:0] op,
      input logic taken, input logic [DATA_W-1:0] pc, input logic [OFFSET_W-1:0] o,
      input logic [DATA_W-1:0] t);
    logic [DATA_W-1:0] seqPc;
    logic [DATA_W-1:0] byteOff;
    seqPc   = pc + 16'd2;
    byteOff = {{(DATA_W-OFFSET_W){o[OFFSET_W-1]}}, o} * 16'd2;  // words to bytes
    if (op == OP_B && taken) return seqPc + byteOff;
    if (op == OP_BR && taken) return t;
    if (op == OP_HLT) return pc;
    return seqPc;
  endfunction

  // all bus tasks start and end on a falling edge
  task automatic cfgWrite(input logic [CFG_AW-1:0] addr, input logic [DATA_W-1:0] data);
    cfgWe    = 1'b1;
    cfgAddr  = addr;
    cfgWdata = data;
    @(negedge clk);
    cfgWe    = 1'b0;
  endtask

  task automatic readCfg(input logic [CFG_AW-1:0] addr, output logic [DATA_W-1:0] data);
    cfgAddr = addr;
    @(negedge clk);
    data = cfgRdata;  // settled for half a period
  endtask

  task automatic memWrite(input logic [DATA_W-1:0] pc, input logic [DATA_W-1:0] data);
    memWe    = 1'b1;
    memAddr  = pc[IMEM_AW:1];  // byte pc to word
    memWdata = data;
    @(negedge clk);
    memWe    = 1'b0;
  endtask

  task automatic creditPulse();
    creditReturn = 1'b1;
    @(negedge clk);
    creditReturn = 1'b0;
  endtask

  task automatic waitIssue(input string what);
    int cycles;
    cycles = 0;
    while (!outValid) begin
      if (cycles == ISSUE_WAIT) begin
        $display("no instruction was issued while waiting for the %s", what);
        endWithFailure();
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic expectIdle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      checkValue("outValid", outValid, 0);
    end
  endtask

  // run limit scales with the table length
  initial begin
    #((NUM_ROWS * 20 + 200) * CLK_PERIOD);
    $display("timeout, the test did not finish in the expected time");
    endWithFailure();
  end

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    memWe = 1'b0;
    memAddr = '0;
    memWdata = '0;
    cfgWe = 1'b0;
    cfgAddr = '0;
    cfgWdata = '0;
    creditReturn = 1'b0;
    seed = 32'h30ff;
    checksRun = 0;
    buildTable();
    if (rowFlags.size() != NUM_ROWS) begin
      $display("stimulus table holds %0d rows instead of %0d", rowFlags.size(), NUM_ROWS);
      endWithFailure();
    end
    repeat (5) @(negedge clk);
    rstN = 1'b1;

    // idle state after reset
    checkValue("outValid", outValid, 0);
    readCfg(CFG_STATUS, rdata);
    checkValue("status", rdata, 16'h0000);

    // credits: four issues back to back, then a stall
    for (i = 0; i < 6; i++) memWrite(16'(2 * i), fillerAt(16'(2 * i)));
    cfgWrite(CFG_RUN, 16'h0001);
    for (i = 0; i < FETCH_CREDITS; i++) begin
      waitIssue("initial burst");
      checkValue("outPc", outPc, 2 * i);
      checkValue("outInstr", outInstr, fillerAt(16'(2 * i)));
      @(negedge clk);
    end
    checkValue("outValid", outValid, 0);
    expectIdle(10);
    creditPulse();
    waitIssue("single credit issue");
    checkValue("outPc", outPc, 16'd8);
    expectIdle(3);  // one credit buys one issue
    curPc = 16'd10;

    // table rows, one credit per instruction
    for (i = 0; i < NUM_ROWS; i++) begin
      rnd = $random(seed);
      off = rnd[OFFSET_W-1:0];
      off[OFFSET_W-1] = i[0];  // alternate sign
      if (off[7:0] == 8'hFF) off[1] = 1'b0;  // these wrap onto the branch itself
      rnd = $random(seed);
      tgt = {rnd[DATA_W-1:1], 1'b0};
      if (tgt[IMEM_AW:1] == curPc[IMEM_AW:1]) tgt = tgt + 16'd4;
      instr   = {rowOp[i], rowCond[i], off};
      expNext = expectedNext(rowOp[i], rowTaken[i], curPc, off, tgt);
      cfgWrite(CFG_FLAGS, {{(DATA_W-FLAG_W){1'b0}}, rowFlags[i]});
      cfgWrite(CFG_TARGET, tgt);
      readCfg(CFG_FLAGS, rdata);
      checkValue("flags", rdata, {{(DATA_W-FLAG_W){1'b0}}, rowFlags[i]});
      readCfg(CFG_TARGET, rdata);
      checkValue("branchTarget", rdata, tgt);
      memWrite(curPc, instr);
      memWrite(curPc + 16'd2, fillerAt(curPc + 16'd2));
      memWrite(expNext, fillerAt(expNext));
      creditPulse();
      waitIssue("table instruction");
      checkValue("outPc", outPc, curPc);
      checkValue("outInstr", outInstr, instr);
      checkValue("outBranch", outBranch, rowTaken[i]);
      creditPulse();
      waitIssue("successor instruction");
      checkValue("outPc", outPc, expNext);
      checkValue("outInstr", outInstr, fillerAt(expNext));
      checkValue("outBranch", outBranch, 0);
      curPc = expNext + 16'd2;
    end

    // halt and restart
    hltPc = curPc;
    memWrite(hltPc, HLT_INSTR);
    memWrite(hltPc + 16'd2, fillerAt(hltPc + 16'd2));
    creditPulse();
    waitIssue("HLT");
    checkValue("outPc", outPc, hltPc);
    checkValue("outInstr", outInstr, HLT_INSTR);
    checkValue("outBranch", outBranch, 0);
    readCfg(CFG_STATUS, rdata);
    checkValue("status", rdata, 16'h0001);
    creditPulse();  // credit is there, halt must still block
    checkValue("outValid", outValid, 0);
    expectIdle(10);
    cfgWrite(CFG_RUN, 16'h0001);  // clears halted
    waitIssue("restart after HLT");
    checkValue("outPc", outPc, hltPc);
    checkValue("outInstr", outInstr, HLT_INSTR);
    readCfg(CFG_STATUS, rdata);
    checkValue("status", rdata, 16'h0001);  // parked on the same HLT again
    readCfg(CFG_RUN, rdata);
    checkValue("run", rdata, 16'h0001);

    if (checksRun > 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("no checks were executed");
      endWithFailure();
    end
  end

endmodule

//--- src.f
design/isaPkg.sv
design/fetchPkg.sv
design/pcControl.sv
design/fetchCtrlRegs.sv
design/instrMem.sv
design/fetchUnit.sv
design/fetchTop.sv
dv/fetchTb.sv
